// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_rvvi_trace
FILELIST  := rvvi_trace_top.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^TEST OK$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/csr_merge.sv ====
// CSR value reconstruction from the retirement port
//   Value is write data under the write mask, read data elsewhere
//   Per-CSR written flag for each retirement
`timescale 1ns/10ps

module csr_merge (
   input  logic                                                        rvvi,
   input  logic                                                        rst_n_i,
   input  logic                                                        retire_new_i,
   input  logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_rdata_i,
   input  logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_wdata_i,
   input  logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_rmask_i,
   input  logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_wmask_i,
   output logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_value_o,
   output logic [rvvi_trace_pkg::NUM_CSR-1:0]                          csr_wb_o
);

   import rvvi_trace_pkg::*;

   //////////////////////////////////////////////////
   // One merge slice per tracked CSR
   //////////////////////////////////////////////////

   for (genvar i = 0; i < NUM_CSR; i++) begin : g_csr
      localparam csr_idx_e IDX = csr_idx_e'(i);

      logic [XLEN-1:0] merged;
      logic            touched;

      assign merged  = (csr_wdata_i[IDX] & csr_wmask_i[IDX]) |
                       (csr_rdata_i[IDX] & ~csr_wmask_i[IDX]);
      assign touched = (|csr_rmask_i[IDX]) || (|csr_wmask_i[IDX]);

      always_ff @(posedge rvvi) begin
         if (!rst_n_i) begin
            csr_value_o[IDX] <= '0;
            csr_wb_o[IDX]    <= 1'b0;
         end else begin
            // Flag is per retirement, cleared on idle cycles
            csr_wb_o[IDX] <= retire_new_i && touched;
            if (retire_new_i) begin
               csr_value_o[IDX] <= merged;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // Assertions
   //////////////////////////////////////////////////

   // Masks only come with a retirement accepted by the counter
   a_mask_needs_retire : assert property (
      @(posedge rvvi) disable iff (!rst_n_i)
      !retire_new_i |-> ((csr_rmask_i == '0) && (csr_wmask_i == '0))
   ) else $error("CSR mask set outside a new retirement");

endmodule

// ==== logic/gpr_shadow.sv ====
// Shadow of the general purpose registers
//   Written from the retirement destination port
//   One-hot write flag per retirement
//   Asynchronous read port
`timescale 1ns/10ps

module gpr_shadow (
   input  logic                                rvvi,
   input  logic                                rst_n_i,
   input  logic                                retire_new_i,
   input  logic [rvvi_trace_pkg::GPR_AW-1:0]   rvfi_rd_addr_i,
   input  logic [rvvi_trace_pkg::XLEN-1:0]     rvfi_rd_wdata_i,
   input  logic [rvvi_trace_pkg::GPR_AW-1:0]   gpr_raddr_i,
   output logic [rvvi_trace_pkg::XLEN-1:0]     gpr_rdata_o,
   output logic [rvvi_trace_pkg::GPR_NUM-1:0]  gpr_wb_o
);

   import rvvi_trace_pkg::*;

   logic [XLEN-1:0] regs_q [GPR_NUM];
   logic            rd_write;

   // x0 is hardwired, never a write target
   assign rd_write = retire_new_i && (rvfi_rd_addr_i != '0);

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         for (int r = 0; r < GPR_NUM; r++) begin
            regs_q[r] <= '0;
         end
         gpr_wb_o <= '0;
      end else begin
         gpr_wb_o <= '0;
         if (rd_write) begin
            regs_q[rvfi_rd_addr_i]   <= rvfi_rd_wdata_i;
            gpr_wb_o[rvfi_rd_addr_i] <= 1'b1;
         end
      end
   end

   // Entry 0 stays at its reset value
   assign gpr_rdata_o = regs_q[gpr_raddr_i];

   //////////////////////////////////////////////////
   // Assertions
   //////////////////////////////////////////////////

   a_x0_zero : assert property (
      @(posedge rvvi) disable iff (!rst_n_i)
      (regs_q[0] == '0) && !gpr_wb_o[0]
   ) else $error("Register 0 was written");

endmodule

// ==== logic/net_event_fsm.sv ====
// Trap classification and asynchronous net levels
//   Traps that never retire: exception, ebreak and trigger into debug
//   NMI tracker with its cause
//   Instruction bus fault tracker
`timescale 1ns/10ps

module net_event_fsm (
   input  logic                                     rvvi,
   input  logic                                     rst_n_i,
   input  logic                                     retire_new_i,
   input  logic                                     rvfi_trap_i,
   input  logic                                     rvfi_trap_exception_i,
   input  logic                                     rvfi_trap_debug_i,
   input  logic [rvvi_trace_pkg::EXC_CAUSE_W-1:0]   rvfi_exc_cause_i,
   input  logic [rvvi_trace_pkg::DBG_CAUSE_W-1:0]   rvfi_dbg_cause_i,
   input  logic                                     rvfi_intr_i,
   input  logic                                     rvfi_intr_interrupt_i,
   input  logic [rvvi_trace_pkg::INTR_CAUSE_W-1:0]  rvfi_intr_cause_i,
   input  logic                                     rvfi_nmip_i,
   output logic                                     trap_o,
   output logic                                     nmi_o,
   output logic [rvvi_trace_pkg::INTR_CAUSE_W-1:0]  nmi_cause_o,
   output logic                                     ibus_fault_o
);

   import rvvi_trace_pkg::*;

   fault_state_e nmi_state_q;
   fault_state_e ibus_state_q;
   logic         trap_hit;
   logic         nmi_hit;
   logic         ibus_hit;

   // Tracker step, state only moves on a new retirement
   function automatic fault_state_e fault_next(input fault_state_e cur,
                                               input logic         upd,
                                               input logic         hit);
      if (!upd) begin
         return cur;
      end
      return hit ? FAULT_ACTIVE : FAULT_IDLE;
   endfunction

   //////////////////////////////////////////////////
   // Event decode
   //////////////////////////////////////////////////

   assign trap_hit = rvfi_trap_i &&
                     (rvfi_trap_exception_i ||
                      (rvfi_trap_debug_i && ((rvfi_dbg_cause_i == DBG_CAUSE_EBREAK) ||
                                             (rvfi_dbg_cause_i == DBG_CAUSE_TRIGGER))));

   // Load or store bus error NMI, or pending bit reported by the core
   assign nmi_hit = (rvfi_intr_i && rvfi_intr_interrupt_i &&
                     ((rvfi_intr_cause_i == NMI_LOAD_CAUSE) ||
                      (rvfi_intr_cause_i == NMI_STORE_CAUSE))) ||
                    rvfi_nmip_i;

   assign ibus_hit = rvfi_trap_i && rvfi_trap_exception_i &&
                     (rvfi_exc_cause_i == EXC_INSTR_BUS_FAULT);

   //////////////////////////////////////////////////
   // State
   //////////////////////////////////////////////////

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         trap_o       <= 1'b0;
         nmi_state_q  <= FAULT_IDLE;
         ibus_state_q <= FAULT_IDLE;
         nmi_cause_o  <= '0;
      end else begin
         nmi_state_q  <= fault_next(nmi_state_q, retire_new_i, nmi_hit);
         ibus_state_q <= fault_next(ibus_state_q, retire_new_i, ibus_hit);
         if (retire_new_i) begin
            trap_o <= trap_hit;
         end
         // Cause follows every NMI retirement, even while already active
         if (retire_new_i && nmi_hit) begin
            nmi_cause_o <= rvfi_intr_cause_i;
         end
      end
   end

   assign nmi_o        = (nmi_state_q == FAULT_ACTIVE);
   assign ibus_fault_o = (ibus_state_q == FAULT_ACTIVE);

   //////////////////////////////////////////////////
   // Assertions
   //////////////////////////////////////////////////

   // A fetch bus fault is always reported as a trap as well
   a_ibus_is_trap : assert property (
      @(posedge rvvi) disable iff (!rst_n_i)
      ibus_fault_o |-> trap_o
   ) else $error("Bus fault level without trap");

endmodule

// ==== logic/retire_counter.sv ====
// Retirement detection by order number
//   Flags new retirements combinationally
//   Counts retired instructions
//   Registers instruction word and PC for the trace
`timescale 1ns/10ps

module retire_counter (
   input  logic                                rvvi,
   input  logic                                rst_n_i,
   input  logic                                rvfi_valid_i,
   input  logic [rvvi_trace_pkg::ORDER_W-1:0]  rvfi_order_i,
   input  logic [rvvi_trace_pkg::XLEN-1:0]     rvfi_insn_i,
   input  logic [rvvi_trace_pkg::XLEN-1:0]     rvfi_pc_rdata_i,
   output logic                                retire_new_o,
   output logic                                retire_valid_o,
   output logic [rvvi_trace_pkg::XLEN-1:0]     retire_count_o,
   output logic [rvvi_trace_pkg::XLEN-1:0]     insn_o,
   output logic [rvvi_trace_pkg::XLEN-1:0]     pc_o
);

   import rvvi_trace_pkg::*;

   logic [ORDER_W-1:0] last_order_q;
   logic               order_seen_q;

   // First valid retirement after reset is always new
   assign retire_new_o = rvfi_valid_i && (!order_seen_q || (rvfi_order_i != last_order_q));

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         last_order_q   <= '0;
         order_seen_q   <= 1'b0;
         retire_valid_o <= 1'b0;
         retire_count_o <= '0;
      end else begin
         retire_valid_o <= retire_new_o;
         if (retire_new_o) begin
            last_order_q   <= rvfi_order_i;
            order_seen_q   <= 1'b1;
            retire_count_o <= retire_count_o + 1'b1;
         end
      end
   end

   // Trace payload, only meaningful with retire_valid_o
   always_ff @(posedge rvvi) begin
      if (retire_new_o) begin
         insn_o <= rvfi_insn_i;
         pc_o   <= rvfi_pc_rdata_i;
      end
   end

   //////////////////////////////////////////////////
   // Assertions
   //////////////////////////////////////////////////

   // Two accepted retirements in a row never share an order
   a_order_changes : assert property (
      @(posedge rvvi) disable iff (!rst_n_i)
      (retire_new_o && order_seen_q) |=> (last_order_q != $past(last_order_q))
   ) else $error("Accepted order repeats the previous one");

endmodule

// ==== logic/rvvi_trace_pkg.sv ====
// Shared definitions for the retirement-trace converter
//   Data, order and register address widths
//   Tracked CSR indices
//   Trap, debug and interrupt cause codes
//   States of the NMI and bus-fault trackers
package rvvi_trace_pkg;

   //////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////

   // Core data width
   localparam int XLEN    = 32;

   // Retirement order number
   localparam int ORDER_W = 64;

   // General purpose register file
   localparam int GPR_NUM = 32;
   localparam int GPR_AW  = 5;

   //////////////////////////////////////////////////
   // Tracked CSRs
   //////////////////////////////////////////////////

   localparam int NUM_CSR = 5;

   // Index into the CSR value and mask arrays
   typedef enum logic [2:0] {
      CSR_MSTATUS,
      CSR_MIE,
      CSR_MTVEC,
      CSR_MEPC,
      CSR_MCAUSE
   } csr_idx_e;

   //////////////////////////////////////////////////
   // Trap and interrupt causes
   //////////////////////////////////////////////////

   // Cause field widths as seen on the retirement port
   localparam int EXC_CAUSE_W  = 6;
   localparam int DBG_CAUSE_W  = 3;
   localparam int INTR_CAUSE_W = 11;

   // Instruction fetch bus error
   localparam logic [EXC_CAUSE_W-1:0] EXC_INSTR_BUS_FAULT = 6'd24;

   // Debug entries that never retire the instruction
   localparam logic [DBG_CAUSE_W-1:0] DBG_CAUSE_EBREAK  = 3'd1;
   localparam logic [DBG_CAUSE_W-1:0] DBG_CAUSE_TRIGGER = 3'd2;

   // NMI on data bus error, load or store side
   localparam logic [INTR_CAUSE_W-1:0] NMI_LOAD_CAUSE  = 11'd1024;
   localparam logic [INTR_CAUSE_W-1:0] NMI_STORE_CAUSE = 11'd1025;

   //////////////////////////////////////////////////
   // Net level trackers
   //////////////////////////////////////////////////

   // Shared by the NMI and the instruction bus fault trackers
   typedef enum logic {
      FAULT_IDLE,
      FAULT_ACTIVE
   } fault_state_e;

endpackage

// ==== logic/rvvi_trace_top.sv ====
// Retirement-trace converter top level
//   Order based retirement detection and counting
//   Trap classification with NMI and bus fault net levels
//   CSR value reconstruction and GPR shadow
`timescale 1ns/10ps

module rvvi_trace_top (
   input  logic                                                        rvvi,
   input  logic                                                        rst_n_i,
   // Retirement port
   input  logic                                                        rvfi_valid_i,
   input  logic [rvvi_trace_pkg::ORDER_W-1:0]                          rvfi_order_i,
   input  logic [rvvi_trace_pkg::XLEN-1:0]                             rvfi_insn_i,
   input  logic [rvvi_trace_pkg::XLEN-1:0]                             rvfi_pc_rdata_i,
   input  logic                                                        rvfi_trap_i,
   input  logic                                                        rvfi_trap_exception_i,
   input  logic                                                        rvfi_trap_debug_i,
   input  logic [rvvi_trace_pkg::EXC_CAUSE_W-1:0]                      rvfi_exc_cause_i,
   input  logic [rvvi_trace_pkg::DBG_CAUSE_W-1:0]                      rvfi_dbg_cause_i,
   input  logic                                                        rvfi_intr_i,
   input  logic                                                        rvfi_intr_interrupt_i,
   input  logic [rvvi_trace_pkg::INTR_CAUSE_W-1:0]                     rvfi_intr_cause_i,
   input  logic                                                        rvfi_nmip_i,
   input  logic [rvvi_trace_pkg::GPR_AW-1:0]                           rvfi_rd_addr_i,
   input  logic [rvvi_trace_pkg::XLEN-1:0]                             rvfi_rd_wdata_i,
   input  logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_rdata_i,
   input  logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_wdata_i,
   input  logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_rmask_i,
   input  logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_wmask_i,
   // Shadow register read port
   input  logic [rvvi_trace_pkg::GPR_AW-1:0]                           gpr_raddr_i,
   // Trace state towards the reference model
   output logic                                                        retire_valid_o,
   output logic [rvvi_trace_pkg::XLEN-1:0]                             retire_count_o,
   output logic [rvvi_trace_pkg::XLEN-1:0]                             insn_o,
   output logic [rvvi_trace_pkg::XLEN-1:0]                             pc_o,
   output logic                                                        trap_o,
   output logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_value_o,
   output logic [rvvi_trace_pkg::NUM_CSR-1:0]                          csr_wb_o,
   output logic [rvvi_trace_pkg::XLEN-1:0]                             gpr_rdata_o,
   output logic [rvvi_trace_pkg::GPR_NUM-1:0]                          gpr_wb_o,
   output logic                                                        nmi_o,
   output logic [rvvi_trace_pkg::INTR_CAUSE_W-1:0]                     nmi_cause_o,
   output logic                                                        ibus_fault_o
);

   // Single point where a retirement is judged new
   logic retire_new;

   retire_counter u_retire_counter (
      .rvvi            (rvvi),
      .rst_n_i         (rst_n_i),
      .rvfi_valid_i    (rvfi_valid_i),
      .rvfi_order_i    (rvfi_order_i),
      .rvfi_insn_i     (rvfi_insn_i),
      .rvfi_pc_rdata_i (rvfi_pc_rdata_i),
      .retire_new_o    (retire_new),
      .retire_valid_o  (retire_valid_o),
      .retire_count_o  (retire_count_o),
      .insn_o          (insn_o),
      .pc_o            (pc_o)
   );

   net_event_fsm u_net_event_fsm (
      .rvvi                  (rvvi),
      .rst_n_i               (rst_n_i),
      .retire_new_i          (retire_new),
      .rvfi_trap_i           (rvfi_trap_i),
      .rvfi_trap_exception_i (rvfi_trap_exception_i),
      .rvfi_trap_debug_i     (rvfi_trap_debug_i),
      .rvfi_exc_cause_i      (rvfi_exc_cause_i),
      .rvfi_dbg_cause_i      (rvfi_dbg_cause_i),
      .rvfi_intr_i           (rvfi_intr_i),
      .rvfi_intr_interrupt_i (rvfi_intr_interrupt_i),
      .rvfi_intr_cause_i     (rvfi_intr_cause_i),
      .rvfi_nmip_i           (rvfi_nmip_i),
      .trap_o                (trap_o),
      .nmi_o                 (nmi_o),
      .nmi_cause_o           (nmi_cause_o),
      .ibus_fault_o          (ibus_fault_o)
   );

   csr_merge u_csr_merge (
      .rvvi         (rvvi),
      .rst_n_i      (rst_n_i),
      .retire_new_i (retire_new),
      .csr_rdata_i  (csr_rdata_i),
      .csr_wdata_i  (csr_wdata_i),
      .csr_rmask_i  (csr_rmask_i),
      .csr_wmask_i  (csr_wmask_i),
      .csr_value_o  (csr_value_o),
      .csr_wb_o     (csr_wb_o)
   );

   gpr_shadow u_gpr_shadow (
      .rvvi            (rvvi),
      .rst_n_i         (rst_n_i),
      .retire_new_i    (retire_new),
      .rvfi_rd_addr_i  (rvfi_rd_addr_i),
      .rvfi_rd_wdata_i (rvfi_rd_wdata_i),
      .gpr_raddr_i     (gpr_raddr_i),
      .gpr_rdata_o     (gpr_rdata_o),
      .gpr_wb_o        (gpr_wb_o)
   );

endmodule

// ==== rvvi_trace_top.f ====
logic/rvvi_trace_pkg.sv
logic/retire_counter.sv
logic/net_event_fsm.sv
logic/csr_merge.sv
logic/gpr_shadow.sv
logic/rvvi_trace_top.sv
testbench/tb_rvvi_trace.sv

// ==== testbench/tb_rvvi_trace.sv ====
// Testbench for the retirement-trace converter
//   Random retirement stimulus with repeated orders
//   Reference model of the trace outputs
//   Output comparison on the falling edge
//   Watchdog sized from the stimulus length
`timescale 1ns/10ps

module tb_rvvi_trace;

   import rvvi_trace_pkg::*;

   localparam int          CLK_PERIOD   = 8;
   localparam int          RESET_CYCLES = 4;
   localparam int          NUM_CYCLES   = 3000;
   localparam int          WATCHDOG_NS  = (RESET_CYCLES + NUM_CYCLES + 100) * CLK_PERIOD;
   localparam logic [31:0] SEED         = 32'ha751_1f1f;

   logic                                  rvvi;
   logic                                  rst_n_i;
   logic                                  rvfi_valid_i;
   logic [ORDER_W-1:0]                    rvfi_order_i;
   logic [XLEN-1:0]                       rvfi_insn_i;
   logic [XLEN-1:0]                       rvfi_pc_rdata_i;
   logic                                  rvfi_trap_i;
   logic                                  rvfi_trap_exception_i;
   logic                                  rvfi_trap_debug_i;
   logic [EXC_CAUSE_W-1:0]                rvfi_exc_cause_i;
   logic [DBG_CAUSE_W-1:0]                rvfi_dbg_cause_i;
   logic                                  rvfi_intr_i;
   logic                                  rvfi_intr_interrupt_i;
   logic [INTR_CAUSE_W-1:0]               rvfi_intr_cause_i;
   logic                                  rvfi_nmip_i;
   logic [GPR_AW-1:0]                     rvfi_rd_addr_i;
   logic [XLEN-1:0]                       rvfi_rd_wdata_i;
   logic [NUM_CSR-1:0][XLEN-1:0]          csr_rdata_i;
   logic [NUM_CSR-1:0][XLEN-1:0]          csr_wdata_i;
   logic [NUM_CSR-1:0][XLEN-1:0]          csr_rmask_i;
   logic [NUM_CSR-1:0][XLEN-1:0]          csr_wmask_i;
   logic [GPR_AW-1:0]                     gpr_raddr_i;
   logic                                  retire_valid_o;
   logic [XLEN-1:0]                       retire_count_o;
   logic [XLEN-1:0]                       insn_o;
   logic [XLEN-1:0]                       pc_o;
   logic                                  trap_o;
   logic [NUM_CSR-1:0][XLEN-1:0]          csr_value_o;
   logic [NUM_CSR-1:0]                    csr_wb_o;
   logic [XLEN-1:0]                       gpr_rdata_o;
   logic [GPR_NUM-1:0]                    gpr_wb_o;
   logic                                  nmi_o;
   logic [INTR_CAUSE_W-1:0]               nmi_cause_o;
   logic                                  ibus_fault_o;

   // Reference state, one step per sampled cycle
   logic                    m_seen;
   logic [ORDER_W-1:0]      m_last_order;
   logic                    m_valid;
   logic [XLEN-1:0]         m_count;
   logic [XLEN-1:0]         m_insn;
   logic [XLEN-1:0]         m_pc;
   logic                    m_trap;
   logic                    m_nmi;
   logic [INTR_CAUSE_W-1:0] m_nmi_cause;
   logic                    m_ibus;
   logic [XLEN-1:0]         m_csr [NUM_CSR];
   logic [NUM_CSR-1:0]      m_csr_wb;
   logic [XLEN-1:0]         m_gpr [GPR_NUM];
   logic [GPR_NUM-1:0]      m_gpr_wb;

   // Stimulus side record of accepted orders
   logic                    drv_seen;
   logic [ORDER_W-1:0]      drv_last_order;

   logic checks_on;
   int   checks_done;
   int   mismatches;
   int   other_errors;
   int   n_repeat;
   int   n_nmi;
   int   n_ibus;
   int   n_dbg_trap;
   int   n_x0;

   rvvi_trace_top DUT (.*);

   initial begin
      rvvi = 1'b0;
      forever #(CLK_PERIOD / 2) rvvi = ~rvvi;
   end

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   function automatic void model_reset();
      m_seen       = 1'b0;
      m_last_order = '0;
      m_valid      = 1'b0;
      m_count      = '0;
      m_trap       = 1'b0;
      m_nmi        = 1'b0;
      m_nmi_cause  = '0;
      m_ibus       = 1'b0;
      m_csr_wb     = '0;
      m_gpr_wb     = '0;
      for (int i = 0; i < NUM_CSR; i++) begin
         m_csr[i] = '0;
      end
      for (int r = 0; r < GPR_NUM; r++) begin
         m_gpr[r] = '0;
      end
   endfunction

   // Expected trace state after the inputs sampled at this edge
   function automatic void model_step();
      logic new_ret;
      logic nmi_evt;
      new_ret  = rvfi_valid_i && (!m_seen || (rvfi_order_i != m_last_order));
      m_valid  = new_ret;
      m_gpr_wb = '0;
      for (int i = 0; i < NUM_CSR; i++) begin
         m_csr_wb[i] = new_ret && ((csr_rmask_i[i] != '0) || (csr_wmask_i[i] != '0));
      end
      if (rvfi_valid_i && !new_ret) begin
         n_repeat++;
      end
      if (!new_ret) begin
         return;
      end
      m_seen       = 1'b1;
      m_last_order = rvfi_order_i;
      m_count      = m_count + 32'd1;
      m_insn       = rvfi_insn_i;
      m_pc         = rvfi_pc_rdata_i;
      // Exception, or debug entry on ebreak (1) or trigger (2)
      m_trap = rvfi_trap_i && (rvfi_trap_exception_i ||
               (rvfi_trap_debug_i && ((rvfi_dbg_cause_i == 3'd1) || (rvfi_dbg_cause_i == 3'd2))));
      if (m_trap && !rvfi_trap_exception_i) begin
         n_dbg_trap++;
      end
      nmi_evt = (rvfi_intr_i && rvfi_intr_interrupt_i &&
                 ((rvfi_intr_cause_i == 11'd1024) || (rvfi_intr_cause_i == 11'd1025))) ||
                rvfi_nmip_i;
      m_nmi = nmi_evt;
      if (nmi_evt) begin
         m_nmi_cause = rvfi_intr_cause_i;
         n_nmi++;
      end
      m_ibus = rvfi_trap_i && rvfi_trap_exception_i && (rvfi_exc_cause_i == 6'd24);
      if (m_ibus) begin
         n_ibus++;
      end
      for (int i = 0; i < NUM_CSR; i++) begin
         m_csr[i] = (csr_wdata_i[i] & csr_wmask_i[i]) | (csr_rdata_i[i] & ~csr_wmask_i[i]);
      end
      if (rvfi_rd_addr_i == '0) begin
         n_x0++;
      end else begin
         m_gpr[rvfi_rd_addr_i]    = rvfi_rd_wdata_i;
         m_gpr_wb[rvfi_rd_addr_i] = 1'b1;
      end
   endfunction

   always @(posedge rvvi) begin
      if (!rst_n_i) begin
         model_reset();
      end else begin
         model_step();
      end
   end

   //////////////////////////////////////////////////
   // Comparison
   //////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      checks_done++;
      if (got !== want) begin
         mismatches++;
         $display("** Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
      end
   endtask

   task automatic report_gap(input string what);
      other_errors++;
      $display("Stimulus never produced %s", what);
   endtask

   task automatic compare_outputs();
      check_value("retire_valid_o", retire_valid_o, m_valid);
      check_value("retire_count_o", retire_count_o, m_count);
      check_value("trap_o", trap_o, m_trap);
      check_value("nmi_o", nmi_o, m_nmi);
      check_value("nmi_cause_o", nmi_cause_o, m_nmi_cause);
      check_value("ibus_fault_o", ibus_fault_o, m_ibus);
      check_value("csr_wb_o", csr_wb_o, m_csr_wb);
      check_value("gpr_wb_o", gpr_wb_o, m_gpr_wb);
      check_value("gpr_rdata_o", gpr_rdata_o, m_gpr[gpr_raddr_i]);
      for (int i = 0; i < NUM_CSR; i++) begin
         check_value($sformatf("csr_value_o[%0d]", i), csr_value_o[i], m_csr[i]);
      end
      // Payload only carries meaning with a valid retirement
      if (m_valid) begin
         check_value("insn_o", insn_o, m_insn);
         check_value("pc_o", pc_o, m_pc);
      end
   endtask

   always @(negedge rvvi) begin
      if (checks_on) begin
         compare_outputs();
      end
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   function automatic logic [XLEN-1:0] pick_mask(input logic [1:0] sel);
      case (sel)
         2'd0:    return '0;
         2'd1:    return '1;
         default: return $urandom();
      endcase
   endfunction

   task automatic drive_cycle();
      logic [31:0]        r;
      logic [ORDER_W-1:0] order;
      logic               valid;
      logic               new_ret;
      r     = $urandom();
      valid = (r[7:6] != 2'd0);
      // Order 0 until the first retirement, then one in eight cycles repeats the last order
      if (!drv_seen || (r[2:0] == 3'd0)) begin
         order = drv_last_order;
      end else begin
         order = drv_last_order + {62'd0, r[4:3]} + 64'd1;
      end
      new_ret = valid && (!drv_seen || (order != drv_last_order));
      if (new_ret) begin
         drv_seen       = 1'b1;
         drv_last_order = order;
      end
      rvfi_valid_i    <= valid;
      rvfi_order_i    <= order;
      rvfi_insn_i     <= $urandom();
      rvfi_pc_rdata_i <= $urandom();

      r = $urandom();
      rvfi_trap_i           <= (r[1:0] == 2'd0);
      rvfi_trap_exception_i <= r[2];
      rvfi_trap_debug_i     <= r[3];
      rvfi_exc_cause_i      <= (r[5:4] == 2'd0) ? 6'd24 : r[11:6];
      rvfi_dbg_cause_i      <= r[14:12];

      r = $urandom();
      rvfi_intr_i           <= r[0];
      rvfi_intr_interrupt_i <= r[1];
      case (r[3:2])
         2'd0:    rvfi_intr_cause_i <= 11'd1024;
         2'd1:    rvfi_intr_cause_i <= 11'd1025;
         2'd2:    rvfi_intr_cause_i <= r[14:4];
         default: rvfi_intr_cause_i <= 11'd11;
      endcase
      rvfi_nmip_i <= (r[18:15] == 4'd0);

      r = $urandom();
      rvfi_rd_addr_i  <= (r[1:0] == 2'd0) ? 5'd0 : r[6:2];
      rvfi_rd_wdata_i <= $urandom();
      gpr_raddr_i     <= r[11:7];

      // Masks stay zero unless the retirement is new
      for (int i = 0; i < NUM_CSR; i++) begin
         r = $urandom();
         csr_rdata_i[i] <= $urandom();
         csr_wdata_i[i] <= $urandom();
         csr_rmask_i[i] <= new_ret ? pick_mask(r[1:0]) : '0;
         csr_wmask_i[i] <= new_ret ? pick_mask(r[3:2]) : '0;
      end
   endtask

   task automatic drive_idle();
      rvfi_valid_i <= 1'b0;
      csr_rmask_i  <= '0;
      csr_wmask_i  <= '0;
   endtask

   initial begin
      void'($urandom(SEED));
      rst_n_i               = 1'b0;
      rvfi_valid_i          = 1'b0;
      rvfi_order_i          = '0;
      rvfi_insn_i           = '0;
      rvfi_pc_rdata_i       = '0;
      rvfi_trap_i           = 1'b0;
      rvfi_trap_exception_i = 1'b0;
      rvfi_trap_debug_i     = 1'b0;
      rvfi_exc_cause_i      = '0;
      rvfi_dbg_cause_i      = '0;
      rvfi_intr_i           = 1'b0;
      rvfi_intr_interrupt_i = 1'b0;
      rvfi_intr_cause_i     = '0;
      rvfi_nmip_i           = 1'b0;
      rvfi_rd_addr_i        = '0;
      rvfi_rd_wdata_i       = '0;
      csr_rdata_i           = '0;
      csr_wdata_i           = '0;
      csr_rmask_i           = '0;
      csr_wmask_i           = '0;
      gpr_raddr_i           = '0;
      drv_seen              = 1'b0;
      drv_last_order        = '0;
      checks_on             = 1'b0;
      checks_done           = 0;
      mismatches            = 0;
      other_errors          = 0;
      n_repeat              = 0;
      n_nmi                 = 0;
      n_ibus                = 0;
      n_dbg_trap            = 0;
      n_x0                  = 0;

      // Reset values are checked from the first edge on
      @(posedge rvvi);
      checks_on = 1'b1;
      repeat (RESET_CYCLES - 1) @(posedge rvvi);
      rst_n_i <= 1'b1;

      for (int c = 0; c < NUM_CYCLES; c++) begin
         drive_cycle();
         @(posedge rvvi);
      end
      drive_idle();
      repeat (3) @(posedge rvvi);

      if (n_repeat == 0) report_gap("a repeated order");
      if (n_nmi == 0) report_gap("an NMI retirement");
      if (n_ibus == 0) report_gap("an instruction bus fault");
      if (n_dbg_trap == 0) report_gap("a debug trap");
      if (n_x0 == 0) report_gap("a write to register 0");

      $display("Summary: %0d checks, %0d value mismatches, %0d other errors",
               checks_done, mismatches, other_errors);
      if ((mismatches == 0) && (other_errors == 0)) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired, run still going after %0d ns", WATCHDOG_NS);
      $display("TEST FAILED");
      $finish;
   end

endmodule
